// File: logic/id_defines.svh
////////////////////////////////////////////////////////////////////////////
// widths and fixed constants of the decode stage
// include in any file that sizes a port or uses a register constant
////////////////////////////////////////////////////////////////////////////
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// data word and register file address
`define REG_W 32
`define REG_ADDR_W 5

// instruction word
`define INST_W 32

// destination of jal
`define LINK_REG 5'd31

// pc offsets for the link value and the sequential fetch
`define PC_LINK_OFS 32'd8
`define PC_SEQ_OFS 32'd4

`endif

// File: logic/id_pkg.sv
////////////////////////////////////////////////////////////////////////////
// encodings and bundles passed between the decode stage blocks
////////////////////////////////////////////////////////////////////////////
`include "id_defines.svh"

package id_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // function field under SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010
    } funct_e;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'b00000000,
        ALU_SRL  = 8'b00000010,
        ALU_JR   = 8'b00001000,
        ALU_ADDU = 8'b00100001,
        ALU_SUBU = 8'b00100011,
        ALU_AND  = 8'b00100100,
        ALU_OR   = 8'b00100101,
        ALU_XOR  = 8'b00100110,
        ALU_NOR  = 8'b00100111,
        ALU_SLT  = 8'b00101010,
        ALU_J    = 8'b01001111,
        ALU_JAL  = 8'b01010000,
        ALU_BEQ  = 8'b01010001,
        ALU_BNE  = 8'b01010010,
        ALU_BLEZ = 8'b01010011,
        ALU_BGTZ = 8'b01010100,
        ALU_SLL  = 8'b01111100,
        ALU_LW   = 8'b11100011,
        ALU_SW   = 8'b11101011
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110,
        SEL_LOAD_STORE  = 3'b111
    } alu_sel_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_GTZ,
        BR_LEZ,
        BR_ABS,
        BR_REG
    } br_kind_e;

    typedef struct packed {
        alu_op_e                aluop;
        alu_sel_e               alusel;
        logic                   reg1_read;
        logic                   reg2_read;
        logic [`REG_ADDR_W-1:0] reg1_addr;
        logic [`REG_ADDR_W-1:0] reg2_addr;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   wreg;
        logic [`REG_W-1:0]      imm;
        br_kind_e               br_kind;
        logic                   link;
    } dec_ctrl_t;

    typedef struct packed {
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] wd;
        logic [`REG_W-1:0]      wdata;
    } fwd_src_t;

    typedef struct packed {
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   is_load;
    } ex_hazard_t;

    typedef struct packed {
        alu_op_e                aluop;
        alu_sel_e               alusel;
        logic [`REG_W-1:0]      reg1;
        logic [`REG_W-1:0]      reg2;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   wreg;
        logic [`REG_W-1:0]      link_addr;
    } id_ex_t;

    typedef struct packed {
        logic              flag;
        logic [`REG_W-1:0] target;
    } branch_t;

endpackage

// File: logic/inst_decoder.sv
////////////////////////////////////////////////////////////////////////////
// combinational instruction decoder, one instruction word in,
// alu op, read enables, destination and immediate out
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "id_defines.svh"

module inst_decoder
    import id_pkg::*;
(
    input  logic [`INST_W-1:0] inst_i,
    output dec_ctrl_t          ctrl_o
);

    opcode_e     op;
    funct_e      funct;
    logic [15:0] imm16;
    logic        imm_wr;
    logic        rtype_wr;
    logic        shamt_op;

    assign op    = opcode_e'(inst_i[31:26]);
    assign funct = funct_e'(inst_i[5:0]);
    assign imm16 = inst_i[15:0];

    always_comb
    begin
        imm_wr           = 1'b0;
        rtype_wr         = 1'b0;
        shamt_op         = 1'b0;
        ctrl_o           = '0;
        ctrl_o.aluop     = ALU_NOP;
        ctrl_o.alusel    = SEL_NOP;
        ctrl_o.br_kind   = BR_NONE;
        ctrl_o.reg1_addr = inst_i[25:21];
        ctrl_o.reg2_addr = inst_i[20:16];
        // sign-extended unless the opcode says otherwise
        ctrl_o.imm       = {{16{imm16[15]}}, imm16};
        case (op)
            OP_ORI, OP_ANDI, OP_XORI:
            begin
                imm_wr        = 1'b1;
                ctrl_o.alusel = SEL_LOGIC;
                ctrl_o.imm    = {16'h0, imm16};
                ctrl_o.aluop  = (op == OP_ORI) ? ALU_OR : (op == OP_ANDI) ? ALU_AND : ALU_XOR;
            end
            OP_LUI:
            begin
                // rs is $0, so or-ing gives the shifted value
                imm_wr        = 1'b1;
                ctrl_o.aluop  = ALU_OR;
                ctrl_o.alusel = SEL_LOGIC;
                ctrl_o.imm    = {imm16, 16'h0};
            end
            OP_ADDIU, OP_SLTI:
            begin
                imm_wr        = 1'b1;
                ctrl_o.alusel = SEL_ARITH;
                ctrl_o.aluop  = (op == OP_ADDIU) ? ALU_ADDU : ALU_SLT;
            end
            OP_LW:
            begin
                imm_wr        = 1'b1;
                ctrl_o.aluop  = ALU_LW;
                ctrl_o.alusel = SEL_LOAD_STORE;
            end
            OP_SW:
            begin
                ctrl_o.aluop     = ALU_SW;
                ctrl_o.alusel    = SEL_LOAD_STORE;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.reg2_read = 1'b1;
            end
            OP_BEQ, OP_BNE:
            begin
                ctrl_o.aluop     = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
                ctrl_o.alusel    = SEL_JUMP_BRANCH;
                ctrl_o.br_kind   = (op == OP_BEQ) ? BR_EQ : BR_NE;
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.reg2_read = 1'b1;
            end
            OP_BGTZ, OP_BLEZ:
            begin
                ctrl_o.aluop     = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
                ctrl_o.alusel    = SEL_JUMP_BRANCH;
                ctrl_o.br_kind   = (op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
                ctrl_o.reg1_read = 1'b1;
            end
            OP_J:
            begin
                ctrl_o.aluop   = ALU_J;
                ctrl_o.alusel  = SEL_JUMP_BRANCH;
                ctrl_o.br_kind = BR_ABS;
            end
            OP_JAL:
            begin
                ctrl_o.aluop   = ALU_JAL;
                ctrl_o.alusel  = SEL_JUMP_BRANCH;
                ctrl_o.br_kind = BR_ABS;
                ctrl_o.link    = 1'b1;
                ctrl_o.wreg    = 1'b1;
                ctrl_o.wd      = `LINK_REG;
            end
            OP_SPECIAL:
            begin
                rtype_wr = 1'b1;
                case (funct)
                    FN_OR, FN_AND, FN_XOR, FN_NOR:
                    begin
                        ctrl_o.alusel = SEL_LOGIC;
                        ctrl_o.aluop  = (funct == FN_OR)  ? ALU_OR  :
                                        (funct == FN_AND) ? ALU_AND :
                                        (funct == FN_XOR) ? ALU_XOR : ALU_NOR;
                    end
                    FN_ADDU, FN_SUBU, FN_SLT:
                    begin
                        ctrl_o.alusel = SEL_ARITH;
                        ctrl_o.aluop  = (funct == FN_ADDU) ? ALU_ADDU :
                                        (funct == FN_SUBU) ? ALU_SUBU : ALU_SLT;
                    end
                    FN_SLL, FN_SRL:
                    begin
                        // shift amount travels as operand 1
                        shamt_op      = 1'b1;
                        ctrl_o.alusel = SEL_SHIFT;
                        ctrl_o.aluop  = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        ctrl_o.imm    = {27'h0, inst_i[10:6]};
                    end
                    FN_JR:
                    begin
                        rtype_wr         = 1'b0;
                        ctrl_o.aluop     = ALU_JR;
                        ctrl_o.alusel    = SEL_JUMP_BRANCH;
                        ctrl_o.br_kind   = BR_REG;
                        ctrl_o.reg1_read = 1'b1;
                    end
                    default:
                    begin
                        rtype_wr = 1'b0;
                    end
                endcase
            end
            default:
            begin
            end
        endcase

        // immediate forms write rt
        if (imm_wr)
        begin
            ctrl_o.reg1_read = 1'b1;
            ctrl_o.wreg      = 1'b1;
            ctrl_o.wd        = inst_i[20:16];
        end
        // register forms write rd
        if (rtype_wr)
        begin
            ctrl_o.reg1_read = !shamt_op;
            ctrl_o.reg2_read = 1'b1;
            ctrl_o.wreg      = 1'b1;
            ctrl_o.wd        = inst_i[15:11];
        end
    end

endmodule

// File: logic/operand_forward.sv
////////////////////////////////////////////////////////////////////////////
// picks one source operand from execute, memory, register file or
// immediate, and flags a load-use hazard on that read port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "id_defines.svh"

module operand_forward
    import id_pkg::*;
(
    input  logic                   read_i,
    input  logic [`REG_ADDR_W-1:0] addr_i,
    input  logic [`REG_W-1:0]      reg_data_i,
    input  logic [`REG_W-1:0]      imm_i,
    input  ex_hazard_t             ex_i,
    input  logic [`REG_W-1:0]      ex_wdata_i,
    input  fwd_src_t               mem_i,
    output logic [`REG_W-1:0]      operand_o,
    output logic                   hazard_o
);

    logic fwd_ok;
    logic ex_hit;
    logic mem_hit;

    // $0 reads always come from the register file
    assign fwd_ok   = read_i && (addr_i != '0);
    assign ex_hit   = fwd_ok && ex_i.wreg && (ex_i.wd == addr_i);
    assign mem_hit  = fwd_ok && mem_i.wreg && (mem_i.wd == addr_i);

    // load data not ready until the load reaches memory
    assign hazard_o = ex_hit && ex_i.is_load;

    always_comb
    begin
        if (hazard_o)
            operand_o = '0;
        else if (ex_hit)
            operand_o = ex_wdata_i;
        else if (mem_hit)
            operand_o = mem_i.wdata;
        else if (read_i)
            operand_o = reg_data_i;
        else
            operand_o = imm_i;
    end

endmodule

// File: logic/branch_resolve.sv
////////////////////////////////////////////////////////////////////////////
// resolves branches and jumps in decode, gives the taken flag, target
// and the jal link address
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "id_defines.svh"

module branch_resolve
    import id_pkg::*;
(
    input  logic [`REG_W-1:0]  pc_i,
    input  logic [`INST_W-1:0] inst_i,
    input  br_kind_e           br_kind_i,
    input  logic [`REG_W-1:0]  reg1_i,
    input  logic [`REG_W-1:0]  reg2_i,
    input  logic               stall_i,
    output branch_t            branch_o,
    output logic [`REG_W-1:0]  link_addr_o
);

    logic [`REG_W-1:0] pc_plus4;
    logic [`REG_W-1:0] rel_target;
    logic [`REG_W-1:0] abs_target;
    logic [`REG_W-1:0] target;
    logic              taken;

    assign pc_plus4   = pc_i + `PC_SEQ_OFS;
    assign rel_target = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign abs_target = {pc_plus4[`REG_W-1 -: 4], inst_i[25:0], 2'b00};

    always_comb
    begin
        taken  = 1'b0;
        target = rel_target;
        case (br_kind_i)
            BR_EQ:  taken = (reg1_i == reg2_i);
            BR_NE:  taken = (reg1_i != reg2_i);
            BR_GTZ: taken = !reg1_i[`REG_W-1] && (reg1_i != '0);
            BR_LEZ: taken = reg1_i[`REG_W-1] || (reg1_i == '0);
            BR_ABS:
            begin
                taken  = 1'b1;
                target = abs_target;
            end
            BR_REG:
            begin
                taken  = 1'b1;
                target = reg1_i;
            end
            default: taken = 1'b0;
        endcase
    end

    // suppressed while the instruction is held for a load
    assign branch_o.flag   = taken && !stall_i;
    assign branch_o.target = branch_o.flag ? target : '0;

    assign link_addr_o = (inst_i[31:26] == OP_JAL) ? pc_i + `PC_LINK_OFS : '0;

endmodule

// File: logic/id_ex_reg.sv
////////////////////////////////////////////////////////////////////////////
// decode to execute pipeline register, loads a bubble on reset or stall
// and reports the instruction it holds back to the forwarding logic
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "id_defines.svh"

module id_ex_reg
    import id_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  dec_ctrl_t         ctrl_i,
    input  logic [`REG_W-1:0] reg1_i,
    input  logic [`REG_W-1:0] reg2_i,
    input  logic [`REG_W-1:0] link_addr_i,
    input  logic              hazard1_i,
    input  logic              hazard2_i,
    output id_ex_t            id_ex_o,
    output ex_hazard_t        ex_o,
    output logic              stall_o
);

    id_ex_t id_ex_d;

    assign stall_o = hazard1_i | hazard2_i;

    always_comb
    begin
        id_ex_d.aluop     = ctrl_i.aluop;
        id_ex_d.alusel    = ctrl_i.alusel;
        id_ex_d.reg1      = reg1_i;
        id_ex_d.reg2      = reg2_i;
        id_ex_d.wd        = ctrl_i.wd;
        id_ex_d.wreg      = ctrl_i.wreg;
        id_ex_d.link_addr = ctrl_i.link ? link_addr_i : '0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i || stall_o)
        begin
            // bubble
            id_ex_o        <= '0;
            id_ex_o.aluop  <= ALU_NOP;
            id_ex_o.alusel <= SEL_NOP;
        end
        else
        begin
            id_ex_o <= id_ex_d;
        end
    end

    // what execute will write, seen by the next decode
    assign ex_o.wreg    = id_ex_o.wreg;
    assign ex_o.wd      = id_ex_o.wd;
    assign ex_o.is_load = (id_ex_o.aluop == ALU_LW);

endmodule

// File: logic/id_stage.sv
////////////////////////////////////////////////////////////////////////////
// decode stage top, decoder, operand forwarding, branch resolution and
// the decode to execute register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "id_defines.svh"

module id_stage
    import id_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [`REG_W-1:0]      pc_i,
    input  logic [`INST_W-1:0]     inst_i,
    input  logic [`REG_W-1:0]      reg1_data_i,
    input  logic [`REG_W-1:0]      reg2_data_i,
    input  logic [`REG_W-1:0]      ex_wdata_i,
    input  fwd_src_t               mem_fwd_i,
    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,
    output branch_t                branch_o,
    output logic                   stall_o,
    output id_ex_t                 id_ex_o
);

    dec_ctrl_t         ctrl;
    ex_hazard_t        ex_haz;
    logic [`REG_W-1:0] reg1;
    logic [`REG_W-1:0] reg2;
    logic [`REG_W-1:0] link_addr;
    logic              hazard1;
    logic              hazard2;

    // register file read port
    assign reg1_read_o = ctrl.reg1_read;
    assign reg2_read_o = ctrl.reg2_read;
    assign reg1_addr_o = ctrl.reg1_addr;
    assign reg2_addr_o = ctrl.reg2_addr;

    inst_decoder u_dec (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    operand_forward u_fwd1 (
        .read_i     (ctrl.reg1_read),
        .addr_i     (ctrl.reg1_addr),
        .reg_data_i (reg1_data_i),
        .imm_i      (ctrl.imm),
        .ex_i       (ex_haz),
        .ex_wdata_i (ex_wdata_i),
        .mem_i      (mem_fwd_i),
        .operand_o  (reg1),
        .hazard_o   (hazard1)
    );

    operand_forward u_fwd2 (
        .read_i     (ctrl.reg2_read),
        .addr_i     (ctrl.reg2_addr),
        .reg_data_i (reg2_data_i),
        .imm_i      (ctrl.imm),
        .ex_i       (ex_haz),
        .ex_wdata_i (ex_wdata_i),
        .mem_i      (mem_fwd_i),
        .operand_o  (reg2),
        .hazard_o   (hazard2)
    );

    branch_resolve u_br (
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .br_kind_i   (ctrl.br_kind),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .stall_i     (stall_o),
        .branch_o    (branch_o),
        .link_addr_o (link_addr)
    );

    id_ex_reg u_idex (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ctrl_i      (ctrl),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .link_addr_i (link_addr),
        .hazard1_i   (hazard1),
        .hazard2_i   (hazard2),
        .id_ex_o     (id_ex_o),
        .ex_o        (ex_haz),
        .stall_o     (stall_o)
    );

endmodule

// File: test/id_checker.sv
////////////////////////////////////////////////////////////////////////////
// assertions on stall and the decode register, bound into the decode stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module id_checker (
    input logic clk,
    input logic rst_n_i,
    input logic stall_i,
    input logic branch_flag_i,
    input logic id_ex_wreg_i
);

    // a held instruction never redirects fetch
    no_branch_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |-> !branch_flag_i)
        else $error("branch flag raised during stall");

    bubble_after_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> !id_ex_wreg_i)
        else $error("decode register writes after stall");

    bubble_after_reset: assert property (@(posedge clk)
        !rst_n_i |=> !id_ex_wreg_i)
        else $error("decode register writes after reset");

endmodule

bind id_stage id_checker u_chk (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_o),
    .branch_flag_i (branch_o.flag),
    .id_ex_wreg_i  (id_ex_o.wreg)
);

// File: test/tb_id_stage.sv
////////////////////////////////////////////////////////////////////////////
// table-driven testbench for the decode stage, with a register file model,
// a forwarding reference and a branch reference
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "id_defines.svh"

module tb_id_stage
    import id_pkg::*;
;

    localparam logic [1:0] SRC_RF  = 2'd0;
    localparam logic [1:0] SRC_EX  = 2'd1;
    localparam logic [1:0] SRC_MEM = 2'd2;
    localparam logic [1:0] SRC_IMM = 2'd3;
    localparam logic [31:0] SEED   = 32'h3edb_22d8;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] ex_wdata;
        fwd_src_t    mem;
        alu_op_e     aluop;
        alu_sel_e    alusel;
        logic [4:0]  wd;
        logic        wreg;
        logic [1:0]  src1;
        logic [1:0]  src2;
        logic [31:0] imm;
        logic        stall;
    } row_t;

    logic                   clk;
    logic                   rst_n_i;
    logic [`REG_W-1:0]      pc_i;
    logic [`INST_W-1:0]     inst_i;
    logic [`REG_W-1:0]      reg1_data_i;
    logic [`REG_W-1:0]      reg2_data_i;
    logic [`REG_W-1:0]      ex_wdata_i;
    fwd_src_t               mem_fwd_i;
    logic                   reg1_read_o;
    logic                   reg2_read_o;
    logic [`REG_ADDR_W-1:0] reg1_addr_o;
    logic [`REG_ADDR_W-1:0] reg2_addr_o;
    branch_t                branch_o;
    logic                   stall_o;
    id_ex_t                 id_ex_o;

    row_t   rows[$];
    integer errors;

    id_stage uut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // register file contents where $0 reads zero
    function automatic logic [31:0] rf_value(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'h0;
        return xorshift(SEED ^ {27'h0, addr});
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] pick_operand(input row_t r, input logic [1:0] src,
                                                 input logic [4:0] addr);
        case (src)
            SRC_RF:  return rf_value(addr);
            SRC_EX:  return r.ex_wdata;
            SRC_MEM: return r.mem.wdata;
            default: return r.imm;
        endcase
    endfunction

    // branch condition and target from the instruction set rules
    function automatic branch_t expect_branch(input logic [31:0] inst, input logic [31:0] pc,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] seq;
        logic [31:0] rel;
        logic [31:0] tgt;
        logic        taken;
        branch_t     res;
        seq   = pc + 32'd4;
        rel   = seq + {{14{inst[15]}}, inst[15:0], 2'b00};
        tgt   = rel;
        taken = 1'b0;
        case (inst[31:26])
            6'b000100: taken = (a == b);
            6'b000101: taken = (a != b);
            6'b000111: taken = !a[31] && (a != 32'h0);
            6'b000110: taken = a[31] || (a == 32'h0);
            6'b000010, 6'b000011:
            begin
                taken = 1'b1;
                tgt   = {seq[31:28], inst[25:0], 2'b00};
            end
            6'b000000:
            begin
                taken = (inst[5:0] == 6'b001000);
                tgt   = a;
            end
            default: taken = 1'b0;
        endcase
        res.flag   = taken;
        res.target = taken ? tgt : 32'h0;
        return res;
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic [31:0] pc,
                           input logic [31:0] exw, input fwd_src_t mem, input alu_op_e op,
                           input alu_sel_e sel, input logic [4:0] wd, input logic wreg,
                           input logic [1:0] s1, input logic [1:0] s2,
                           input logic [31:0] imm, input logic stall);
        row_t r;
        r.inst     = inst;
        r.pc       = pc;
        r.ex_wdata = exw;
        r.mem      = mem;
        r.aluop    = op;
        r.alusel   = sel;
        r.wd       = wd;
        r.wreg     = wreg;
        r.src1     = s1;
        r.src2     = s2;
        r.imm      = imm;
        r.stall    = stall;
        rows.push_back(r);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] a;
        logic [31:0] b;
        branch_t     br;
        @(negedge clk);
        inst_i     = r.inst;
        pc_i       = r.pc;
        ex_wdata_i = r.ex_wdata;
        mem_fwd_i  = r.mem;
        // register file answers the read addresses
        #1;
        reg1_data_i = rf_value(reg1_addr_o);
        reg2_data_i = rf_value(reg2_addr_o);
        #1;
        a  = pick_operand(r, r.src1, r.inst[25:21]);
        b  = pick_operand(r, r.src2, r.inst[20:16]);
        br = r.stall ? '0 : expect_branch(r.inst, r.pc, a, b);
        // an operand taken from the immediate means that port does not read
        check_val("reg1_read_o", {31'h0, reg1_read_o}, {31'h0, (r.src1 != SRC_IMM)});
        check_val("reg2_read_o", {31'h0, reg2_read_o}, {31'h0, (r.src2 != SRC_IMM)});
        if (r.src1 != SRC_IMM)
            check_val("reg1_addr_o", {27'h0, reg1_addr_o}, {27'h0, r.inst[25:21]});
        if (r.src2 != SRC_IMM)
            check_val("reg2_addr_o", {27'h0, reg2_addr_o}, {27'h0, r.inst[20:16]});
        check_val("stall_o", {31'h0, stall_o}, {31'h0, r.stall});
        check_val("branch_o.flag", {31'h0, branch_o.flag}, {31'h0, br.flag});
        check_val("branch_o.target", branch_o.target, br.target);
        @(posedge clk);
        #1;
        if (r.stall)
        begin
            check_val("id_ex_o.aluop", {24'h0, id_ex_o.aluop}, {24'h0, ALU_NOP});
            check_val("id_ex_o.wreg", {31'h0, id_ex_o.wreg}, 32'h0);
            check_val("id_ex_o.wd", {27'h0, id_ex_o.wd}, 32'h0);
            check_val("id_ex_o.reg1", id_ex_o.reg1, 32'h0);
            check_val("id_ex_o.reg2", id_ex_o.reg2, 32'h0);
        end
        else
        begin
            check_val("id_ex_o.aluop", {24'h0, id_ex_o.aluop}, {24'h0, r.aluop});
            check_val("id_ex_o.alusel", {29'h0, id_ex_o.alusel}, {29'h0, r.alusel});
            check_val("id_ex_o.wd", {27'h0, id_ex_o.wd}, {27'h0, r.wd});
            check_val("id_ex_o.wreg", {31'h0, id_ex_o.wreg}, {31'h0, r.wreg});
            check_val("id_ex_o.reg1", id_ex_o.reg1, a);
            check_val("id_ex_o.reg2", id_ex_o.reg2, b);
            check_val("id_ex_o.link_addr", id_ex_o.link_addr,
                      (r.inst[31:26] == 6'b000011) ? r.pc + 32'd8 : 32'h0);
        end
    endtask

    task automatic wait_reset_bubble();
        integer n;
        n = 0;
        while ((stall_o !== 1'b0 || id_ex_o.wreg !== 1'b0) && n < 10)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= 10)
        begin
            errors++;
            $display("timeout: no bubble in the decode register after reset");
        end
    endtask

    task automatic fill_table();
        fwd_src_t none;
        none = '0;
        add_row(enc_i(OP_ORI, 5'd1, 5'd3, 16'h8001), 32'h0, 32'h0, none, ALU_OR, SEL_LOGIC,
                5'd3, 1'b1, SRC_RF, SRC_IMM, 32'h0000_8001, 1'b0);
        add_row(enc_r(5'd3, 5'd2, 5'd4, 5'd0, FN_ADDU), 32'h4, 32'h1111_2222, none, ALU_ADDU,
                SEL_ARITH, 5'd4, 1'b1, SRC_EX, SRC_RF, 32'h0, 1'b0);
        add_row(enc_r(5'd6, 5'd7, 5'd5, 5'd0, FN_XOR), 32'h8, 32'h0, '{1'b1, 5'd7, 32'ha5a5_0000},
                ALU_XOR, SEL_LOGIC, 5'd5, 1'b1, SRC_RF, SRC_MEM, 32'h0, 1'b0);
        // $0 stays unforwarded even with a matching memory source
        add_row(enc_r(5'd0, 5'd5, 5'd6, 5'd0, FN_SUBU), 32'hc, 32'h42, '{1'b1, 5'd0, 32'hdead},
                ALU_SUBU, SEL_ARITH, 5'd6, 1'b1, SRC_RF, SRC_EX, 32'h0, 1'b0);
        add_row(enc_i(OP_LUI, 5'd0, 5'd7, 16'h1234), 32'h10, 32'h0, none, ALU_OR, SEL_LOGIC,
                5'd7, 1'b1, SRC_RF, SRC_IMM, 32'h1234_0000, 1'b0);
        add_row(enc_i(OP_ADDIU, 5'd1, 5'd8, 16'hfffc), 32'h14, 32'h0, none, ALU_ADDU, SEL_ARITH,
                5'd8, 1'b1, SRC_RF, SRC_IMM, 32'hffff_fffc, 1'b0);
        add_row(enc_i(OP_SLTI, 5'd2, 5'd9, 16'h0005), 32'h18, 32'h0, none, ALU_SLT, SEL_ARITH,
                5'd9, 1'b1, SRC_RF, SRC_IMM, 32'h5, 1'b0);
        add_row(enc_i(OP_ANDI, 5'd3, 5'd10, 16'hf0f0), 32'h1c, 32'h0, none, ALU_AND, SEL_LOGIC,
                5'd10, 1'b1, SRC_RF, SRC_IMM, 32'h0000_f0f0, 1'b0);
        add_row(enc_r(5'd0, 5'd12, 5'd11, 5'd3, FN_SLL), 32'h20, 32'h0, none, ALU_SLL, SEL_SHIFT,
                5'd11, 1'b1, SRC_IMM, SRC_RF, 32'h3, 1'b0);
        add_row(enc_r(5'd0, 5'd14, 5'd13, 5'd31, FN_SRL), 32'h24, 32'h0, none, ALU_SRL,
                SEL_SHIFT, 5'd13, 1'b1, SRC_IMM, SRC_RF, 32'h1f, 1'b0);
        add_row(enc_r(5'd1, 5'd2, 5'd15, 5'd0, FN_NOR), 32'h28, 32'h0, none, ALU_NOR, SEL_LOGIC,
                5'd15, 1'b1, SRC_RF, SRC_RF, 32'h0, 1'b0);
        add_row(enc_r(5'd3, 5'd4, 5'd16, 5'd0, FN_SLT), 32'h2c, 32'h0, none, ALU_SLT, SEL_ARITH,
                5'd16, 1'b1, SRC_RF, SRC_RF, 32'h0, 1'b0);
        add_row(enc_i(OP_LW, 5'd0, 5'd8, 16'h0010), 32'h30, 32'h0, none, ALU_LW, SEL_LOAD_STORE,
                5'd8, 1'b1, SRC_RF, SRC_IMM, 32'h10, 1'b0);
        // a load-use stalls for one bubble and the held instruction then takes the memory value
        add_row(enc_r(5'd8, 5'd2, 5'd9, 5'd0, FN_ADDU), 32'h34, 32'h0, none, ALU_ADDU, SEL_ARITH,
                5'd9, 1'b1, SRC_RF, SRC_RF, 32'h0, 1'b1);
        add_row(enc_r(5'd8, 5'd2, 5'd9, 5'd0, FN_ADDU), 32'h34, 32'h0,
                '{1'b1, 5'd8, 32'hcafe_0008}, ALU_ADDU, SEL_ARITH, 5'd9, 1'b1, SRC_MEM, SRC_RF,
                32'h0, 1'b0);
        add_row(enc_i(OP_SW, 5'd5, 5'd9, 16'h0004), 32'h38, 32'h99, none, ALU_SW,
                SEL_LOAD_STORE, 5'd0, 1'b0, SRC_RF, SRC_EX, 32'h4, 1'b0);
        add_row(enc_i(OP_BEQ, 5'd1, 5'd1, 16'h0010), 32'h100, 32'h0, none, ALU_BEQ,
                SEL_JUMP_BRANCH, 5'd0, 1'b0, SRC_RF, SRC_RF, 32'h10, 1'b0);
        add_row(enc_i(OP_BNE, 5'd1, 5'd1, 16'h0010), 32'h104, 32'h0, none, ALU_BNE,
                SEL_JUMP_BRANCH, 5'd0, 1'b0, SRC_RF, SRC_RF, 32'h10, 1'b0);
        add_row(enc_i(OP_BGTZ, 5'd2, 5'd0, 16'hfffe), 32'h108, 32'h0, none, ALU_BGTZ,
                SEL_JUMP_BRANCH, 5'd0, 1'b0, SRC_RF, SRC_IMM, 32'hffff_fffe, 1'b0);
        add_row(enc_i(OP_BLEZ, 5'd0, 5'd0, 16'h0008), 32'h10c, 32'h0, none, ALU_BLEZ,
                SEL_JUMP_BRANCH, 5'd0, 1'b0, SRC_RF, SRC_IMM, 32'h8, 1'b0);
        add_row({OP_J, 26'h000_1234}, 32'h8000_0100, 32'h0, none, ALU_J, SEL_JUMP_BRANCH,
                5'd0, 1'b0, SRC_IMM, SRC_IMM, 32'h1234, 1'b0);
        add_row({OP_JAL, 26'h000_0040}, 32'h200, 32'h0, none, ALU_JAL, SEL_JUMP_BRANCH,
                `LINK_REG, 1'b1, SRC_IMM, SRC_IMM, 32'h40, 1'b0);
        add_row(enc_r(5'd31, 5'd0, 5'd0, 5'd0, FN_JR), 32'h204, 32'h300, none, ALU_JR,
                SEL_JUMP_BRANCH, 5'd0, 1'b0, SRC_EX, SRC_IMM, 32'h8, 1'b0);
        // unknown opcode
        add_row(32'hfc00_0000, 32'h208, 32'h0, none, ALU_NOP, SEL_NOP, 5'd0, 1'b0, SRC_IMM,
                SRC_IMM, 32'h0, 1'b0);
    endtask

    initial
    begin
        #20000;
        $display("timeout: simulation did not complete");
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        pc_i        = '0;
        inst_i      = 32'hfc00_0000;
        reg1_data_i = '0;
        reg2_data_i = '0;
        ex_wdata_i  = '0;
        mem_fwd_i   = '0;
        errors      = 0;
        fill_table();
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        wait_reset_bubble();
        check_val("id_ex_o.aluop", {24'h0, id_ex_o.aluop}, {24'h0, ALU_NOP});
        check_val("id_ex_o.wd", {27'h0, id_ex_o.wd}, 32'h0);
        check_val("id_ex_o.reg1", id_ex_o.reg1, 32'h0);
        check_val("id_ex_o.reg2", id_ex_o.reg2, 32'h0);
        check_val("branch_o.flag", {31'h0, branch_o.flag}, 32'h0);
        foreach (rows[i])
            apply_row(rows[i]);
        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/id_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/branch_resolve.sv
logic/id_ex_reg.sv
logic/id_stage.sv
test/id_checker.sv
test/tb_id_stage.sv

// File: Makefile
TOP = tb_id_stage

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
